//--- icache_pkg.sv
/*
 * Shared sizes, coherence and tag-packet encodings, and the packet and
 * request structs used by the instruction cache and its testbench
 */
`default_nettype none

package icache_pkg;

  localparam int ways_lp               = 4;
  localparam int sets_lp               = 64;
  localparam int paddr_width_lp        = 32;
  localparam int page_offset_width_lp  = 12;
  localparam int block_width_lp        = 512;
  localparam int instr_width_lp        = 32;
  localparam int index_width_lp        = 6;
  localparam int block_offset_width_lp = 6;
  localparam int tag_width_lp          = paddr_width_lp - index_width_lp - block_offset_width_lp;
  localparam int ptag_width_lp         = paddr_width_lp - page_offset_width_lp;
  localparam int way_id_width_lp       = 2;
  localparam int lru_width_lp          = ways_lp - 1;

  typedef enum logic [0:0] {
    e_coh_i = 1'b0,
    e_coh_s = 1'b1
  } coh_state_e;

  typedef enum logic [1:0] {
    e_tag_set_clear  = 2'b00,
    e_tag_invalidate = 2'b01,
    e_tag_set_tag    = 2'b10
  } tag_opcode_e;

  typedef struct packed {
    coh_state_e                state;
    logic [tag_width_lp-1:0]   tag;
  } tag_entry_s;

  typedef struct packed {
    tag_opcode_e                 opcode;
    logic [index_width_lp-1:0]   index;
    logic [way_id_width_lp-1:0]  way_id;
    coh_state_e                  state;
    logic [tag_width_lp-1:0]     tag;
  } tag_mem_pkt_s;

  typedef struct packed {
    logic [index_width_lp-1:0]   index;
    logic [way_id_width_lp-1:0]  way_id;
    logic [block_width_lp-1:0]   data;
  } data_mem_pkt_s;

  typedef struct packed {
    logic [paddr_width_lp-1:0] addr;
  } cache_req_s;

  typedef struct packed {
    logic [way_id_width_lp-1:0] repl_way;
  } cache_req_metadata_s;

endpackage

`default_nettype wire

//--- icache_tag_array.sv
/*
 * Tag and coherence-state store, all ways of a set in one row.
 * One lookup read or one tag-packet write per cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module icache_tag_array (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   lookup_v_i,
  input  logic [icache_pkg::index_width_lp-1:0]  lookup_index_i,
  input  logic                                   tag_pkt_v_i,
  input  icache_pkg::tag_mem_pkt_s               tag_pkt_i,
  output icache_pkg::tag_entry_s [icache_pkg::ways_lp-1:0] entries_o
);

  import icache_pkg::*;

  tag_entry_s [ways_lp-1:0] mem [sets_lp];

  logic               pkt_we;
  tag_entry_s         wr_entry;
  logic [ways_lp-1:0] state_we;
  logic [ways_lp-1:0] tag_we;

  // lookup owns the port
  assign pkt_we = tag_pkt_v_i & ~lookup_v_i & ~reset_i;

  always_comb begin
    wr_entry = '0;
    state_we = '0;
    tag_we   = '0;
    if (pkt_we) begin
      case (tag_pkt_i.opcode)
        e_tag_set_clear: begin
          state_we = '1;
          tag_we   = '1;
        end
        e_tag_invalidate: begin
          state_we[tag_pkt_i.way_id] = 1'b1;
        end
        e_tag_set_tag: begin
          wr_entry.state             = tag_pkt_i.state;
          wr_entry.tag               = tag_pkt_i.tag;
          state_we[tag_pkt_i.way_id] = 1'b1;
          tag_we[tag_pkt_i.way_id]   = 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < ways_lp; w++) begin
      if (state_we[w]) mem[tag_pkt_i.index][w].state <= wr_entry.state;
      if (tag_we[w]) mem[tag_pkt_i.index][w].tag <= wr_entry.tag;
    end
    if (lookup_v_i) entries_o <= mem[lookup_index_i];
  end

  // set_tag must be visible to a lookup of that set in the very next cycle
  assert property (@(posedge clk_i) disable iff (reset_i)
    (pkt_we && tag_pkt_i.opcode == e_tag_set_tag) ##1
    (lookup_v_i && lookup_index_i == $past(tag_pkt_i.index))
    |=> entries_o[$past(tag_pkt_i.way_id, 2)] == $past(wr_entry, 2));

endmodule

`default_nettype wire

//--- icache_data_array.sv
/*
 * Block store, one block-wide memory per way.
 * All ways read together at lookup. A data packet writes one way.
 */
`timescale 1ns/1ns
`default_nettype none

module icache_data_array (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   lookup_v_i,
  input  logic [icache_pkg::index_width_lp-1:0]  lookup_index_i,
  input  logic                                   data_pkt_v_i,
  input  icache_pkg::data_mem_pkt_s              data_pkt_i,
  output logic [icache_pkg::ways_lp-1:0][icache_pkg::block_width_lp-1:0] blocks_o
);

  import icache_pkg::*;

  logic pkt_we;

  assign pkt_we = data_pkt_v_i & ~lookup_v_i & ~reset_i;

  for (genvar w = 0; w < ways_lp; w++) begin : g_way
    logic [block_width_lp-1:0] mem [sets_lp];
    logic [block_width_lp-1:0] rd_r;
    logic                      way_we;

    assign way_we = pkt_we && (data_pkt_i.way_id == way_id_width_lp'(w));

    always_ff @(posedge clk_i) begin
      if (way_we) mem[data_pkt_i.index] <= data_pkt_i.data;
      if (lookup_v_i) rd_r <= mem[lookup_index_i];
    end

    assign blocks_o[w] = rd_r;
  end

  // way id must name a real way
  assert property (@(posedge clk_i) disable iff (reset_i)
    data_pkt_v_i |-> !$isunknown(data_pkt_i.way_id));

endmodule

`default_nettype wire

//--- icache_lru.sv
/*
 * Pseudo-LRU tree bits per set, with hit update, set clear
 * and replacement-way choice
 */
`timescale 1ns/1ns
`default_nettype none

module icache_lru (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    hit_v_i,
  input  logic [icache_pkg::way_id_width_lp-1:0]  hit_way_i,
  input  logic [icache_pkg::index_width_lp-1:0]   tv_index_i,
  input  logic [icache_pkg::ways_lp-1:0]          way_valid_i,
  input  logic                                    tag_pkt_v_i,
  input  icache_pkg::tag_mem_pkt_s                tag_pkt_i,
  output logic [icache_pkg::way_id_width_lp-1:0]  repl_way_o
);

  import icache_pkg::*;

  logic [lru_width_lp-1:0]    lru_r [sets_lp];
  logic [lru_width_lp-1:0]    lru_cur;
  logic [way_id_width_lp-1:0] tree_way;
  logic                       clear_v;

  assign lru_cur = lru_r[tv_index_i];
  assign clear_v = tag_pkt_v_i && (tag_pkt_i.opcode == e_tag_set_clear);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_lp; s++) lru_r[s] <= '0;
    end else begin
      if (hit_v_i) begin
        // point root and pair bit away from the hit way
        lru_r[tv_index_i][0] <= ~hit_way_i[1];
        if (hit_way_i[1]) begin
          lru_r[tv_index_i][2] <= ~hit_way_i[0];
        end else begin
          lru_r[tv_index_i][1] <= ~hit_way_i[0];
        end
      end
      if (clear_v) lru_r[tag_pkt_i.index] <= '0;
    end
  end

  always_comb begin
    tree_way   = lru_cur[0] ? {1'b1, lru_cur[2]} : {1'b0, lru_cur[1]};
    repl_way_o = tree_way;
    // lowest invalid way beats the tree
    for (int w = ways_lp - 1; w >= 0; w--) begin
      if (!way_valid_i[w]) repl_way_o = way_id_width_lp'(w);
    end
  end

endmodule

`default_nettype wire

//--- icache_miss_fsm.sv
/*
 * Miss FSM. Sends the miss request, the metadata a cycle later,
 * and holds miss until the fill completes
 */
`timescale 1ns/1ns
`default_nettype none

module icache_miss_fsm (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    miss_v_i,
  input  icache_pkg::cache_req_s                  miss_req_i,
  input  logic [icache_pkg::way_id_width_lp-1:0]  repl_way_i,
  input  logic                                    cache_req_ready_i,
  input  logic                                    cache_req_complete_i,
  output icache_pkg::cache_req_s                  cache_req_o,
  output logic                                    cache_req_v_o,
  output icache_pkg::cache_req_metadata_s         cache_req_metadata_o,
  output logic                                    cache_req_metadata_v_o,
  output logic                                    miss_o,
  output logic                                    fetch_ready_o
);

  import icache_pkg::*;

  typedef enum logic [0:0] {
    e_ready     = 1'b0,
    e_wait_fill = 1'b1
  } miss_state_e;

  miss_state_e         state_r;
  miss_state_e         state_n;
  cache_req_metadata_s meta_r;

  // dropped when the engine is not ready, front end replays it
  assign cache_req_v_o = miss_v_i & cache_req_ready_i & (state_r == e_ready);
  assign cache_req_o   = miss_req_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_ready:     if (cache_req_v_o) state_n = e_wait_fill;
      e_wait_fill: if (cache_req_complete_i) state_n = e_ready;
      default:     state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r                <= e_ready;
      cache_req_metadata_v_o <= 1'b0;
    end else begin
      state_r                <= state_n;
      cache_req_metadata_v_o <= cache_req_v_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_req_v_o) meta_r.repl_way <= repl_way_i;
  end

  assign cache_req_metadata_o = meta_r;
  assign miss_o               = (state_r == e_wait_fill);
  assign fetch_ready_o        = ~miss_o & ~cache_req_v_o;

  // engine only completes a fill that was asked for
  assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_complete_i |-> state_r == e_wait_fill);

endmodule

`default_nettype wire

//--- icache_lookup.sv
/*
 * Fetch pipeline. TL and TV registers, tag compare,
 * hit way and instruction select
 */
`timescale 1ns/1ns
`default_nettype none

module icache_lookup (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic [icache_pkg::paddr_width_lp-1:0]   vaddr_i,
  input  logic                                    vaddr_v_i,
  input  logic [icache_pkg::ptag_width_lp-1:0]    ptag_i,
  input  logic                                    ptag_v_i,
  input  logic                                    fetch_ready_i,
  input  logic                                    cache_req_ready_i,
  output logic                                    vaddr_ready_o,
  output logic                                    lookup_v_o,
  output logic [icache_pkg::index_width_lp-1:0]   lookup_index_o,
  input  icache_pkg::tag_entry_s [icache_pkg::ways_lp-1:0] entries_i,
  input  logic [icache_pkg::ways_lp-1:0][icache_pkg::block_width_lp-1:0] blocks_i,
  output logic                                    hit_v_o,
  output logic [icache_pkg::way_id_width_lp-1:0]  hit_way_o,
  output logic [icache_pkg::index_width_lp-1:0]   tv_index_o,
  output logic [icache_pkg::ways_lp-1:0]          way_valid_o,
  output logic                                    miss_v_o,
  output icache_pkg::cache_req_s                  miss_req_o,
  output logic [icache_pkg::instr_width_lp-1:0]   data_o,
  output logic                                    data_v_o
);

  import icache_pkg::*;

  logic                             v_tl_r;
  logic [page_offset_width_lp-1:0]  page_offset_tl_r;
  logic                             tv_we;
  logic                             v_tv_r;
  logic [paddr_width_lp-1:0]        addr_tv_r;
  tag_entry_s [ways_lp-1:0]         entries_tv_r;
  logic [ways_lp-1:0][block_width_lp-1:0] blocks_tv_r;

  logic [tag_width_lp-1:0]            addr_tag_tv;
  logic [block_offset_width_lp-3:0]   word_sel;
  logic                               hit_any;
  logic [block_width_lp-1:0]          hit_block;

  assign vaddr_ready_o  = fetch_ready_i & cache_req_ready_i;
  assign lookup_v_o     = vaddr_v_i & vaddr_ready_o;
  assign lookup_index_o = vaddr_i[block_offset_width_lp +: index_width_lp];

  // no ptag in TL drops the fetch
  assign tv_we = v_tl_r & ptag_v_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
      v_tv_r <= 1'b0;
    end else begin
      v_tl_r <= lookup_v_o;
      v_tv_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_v_o) page_offset_tl_r <= vaddr_i[page_offset_width_lp-1:0];
    if (tv_we) begin
      addr_tv_r    <= {ptag_i, page_offset_tl_r};
      entries_tv_r <= entries_i;
      blocks_tv_r  <= blocks_i;
    end
  end

  assign addr_tag_tv = addr_tv_r[block_offset_width_lp + index_width_lp +: tag_width_lp];
  assign word_sel    = addr_tv_r[2 +: block_offset_width_lp - 2];
  assign tv_index_o  = addr_tv_r[block_offset_width_lp +: index_width_lp];

  always_comb begin
    hit_any   = 1'b0;
    hit_way_o = '0;
    // walk down so the lowest hitting way wins
    for (int w = ways_lp - 1; w >= 0; w--) begin
      way_valid_o[w] = (entries_tv_r[w].state != e_coh_i);
      if (way_valid_o[w] && entries_tv_r[w].tag == addr_tag_tv) begin
        hit_any   = 1'b1;
        hit_way_o = way_id_width_lp'(w);
      end
    end
  end

  assign hit_v_o         = v_tv_r & hit_any;
  assign miss_v_o        = v_tv_r & ~hit_any;
  assign miss_req_o.addr = addr_tv_r;

  assign hit_block = blocks_tv_r[hit_way_o];
  assign data_o    = hit_block[word_sel * instr_width_lp +: instr_width_lp];
  assign data_v_o  = hit_v_o;

endmodule

`default_nettype wire

//--- icache.sv
/*
 * Instruction cache top. Fetch pipeline, tag and data arrays,
 * pseudo-LRU store and miss FSM
 */
`timescale 1ns/1ns
`default_nettype none

module icache (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic [icache_pkg::paddr_width_lp-1:0]  vaddr_i,
  input  logic                                   vaddr_v_i,
  output logic                                   vaddr_ready_o,
  input  logic [icache_pkg::ptag_width_lp-1:0]   ptag_i,
  input  logic                                   ptag_v_i,
  output logic [icache_pkg::instr_width_lp-1:0]  data_o,
  output logic                                   data_v_o,
  output logic                                   miss_o,
  output icache_pkg::cache_req_s                 cache_req_o,
  output logic                                   cache_req_v_o,
  input  logic                                   cache_req_ready_i,
  output icache_pkg::cache_req_metadata_s        cache_req_metadata_o,
  output logic                                   cache_req_metadata_v_o,
  input  logic                                   cache_req_complete_i,
  input  logic                                   tag_mem_pkt_v_i,
  input  icache_pkg::tag_mem_pkt_s               tag_mem_pkt_i,
  output logic                                   tag_mem_pkt_ready_o,
  input  logic                                   data_mem_pkt_v_i,
  input  icache_pkg::data_mem_pkt_s              data_mem_pkt_i,
  output logic                                   data_mem_pkt_ready_o
);

  import icache_pkg::*;

  logic                                   lookup_v;
  logic [index_width_lp-1:0]              lookup_index;
  tag_entry_s [ways_lp-1:0]               entries;
  logic [ways_lp-1:0][block_width_lp-1:0] blocks;
  logic                                   hit_v;
  logic [way_id_width_lp-1:0]             hit_way;
  logic [index_width_lp-1:0]              tv_index;
  logic [ways_lp-1:0]                     way_valid;
  logic                                   miss_v;
  cache_req_s                             miss_req;
  logic [way_id_width_lp-1:0]             repl_way;
  logic                                   fetch_ready;

  // a lookup wins the single memory port
  assign tag_mem_pkt_ready_o  = ~lookup_v;
  assign data_mem_pkt_ready_o = ~lookup_v;

  icache_lookup u_lookup (
    .clk_i, .reset_i, .vaddr_i, .vaddr_v_i, .ptag_i, .ptag_v_i,
    .fetch_ready_i(fetch_ready), .cache_req_ready_i, .vaddr_ready_o,
    .lookup_v_o(lookup_v), .lookup_index_o(lookup_index),
    .entries_i(entries), .blocks_i(blocks),
    .hit_v_o(hit_v), .hit_way_o(hit_way), .tv_index_o(tv_index), .way_valid_o(way_valid),
    .miss_v_o(miss_v), .miss_req_o(miss_req), .data_o, .data_v_o
  );

  icache_tag_array u_tag_array (
    .clk_i, .reset_i, .lookup_v_i(lookup_v), .lookup_index_i(lookup_index),
    .tag_pkt_v_i(tag_mem_pkt_v_i), .tag_pkt_i(tag_mem_pkt_i), .entries_o(entries)
  );

  icache_data_array u_data_array (
    .clk_i, .reset_i, .lookup_v_i(lookup_v), .lookup_index_i(lookup_index),
    .data_pkt_v_i(data_mem_pkt_v_i), .data_pkt_i(data_mem_pkt_i), .blocks_o(blocks)
  );

  icache_lru u_lru (
    .clk_i, .reset_i, .hit_v_i(hit_v), .hit_way_i(hit_way), .tv_index_i(tv_index),
    .way_valid_i(way_valid), .tag_pkt_v_i(tag_mem_pkt_v_i), .tag_pkt_i(tag_mem_pkt_i),
    .repl_way_o(repl_way)
  );

  icache_miss_fsm u_miss_fsm (
    .clk_i, .reset_i, .miss_v_i(miss_v), .miss_req_i(miss_req), .repl_way_i(repl_way),
    .cache_req_ready_i, .cache_req_complete_i, .cache_req_o, .cache_req_v_o,
    .cache_req_metadata_o, .cache_req_metadata_v_o, .miss_o,
    .fetch_ready_o(fetch_ready)
  );

endmodule

`default_nettype wire

//--- icache_tb.sv
/*
 * Testbench for the instruction cache. Clock, reset, DUT, a line-fill
 * model with tags, blocks and pseudo-LRU bits, compare tasks and tests
 */
`timescale 1ns/1ns
`default_nettype none

module icache_tb;

  import icache_pkg::*;

  localparam int timeout_cycles_lp = 200;

  logic                          clk_i;
  logic                          reset_i;
  logic [paddr_width_lp-1:0]     vaddr_i;
  logic                          vaddr_v_i;
  logic                          vaddr_ready_o;
  logic [ptag_width_lp-1:0]      ptag_i;
  logic                          ptag_v_i;
  logic [instr_width_lp-1:0]     data_o;
  logic                          data_v_o;
  logic                          miss_o;
  cache_req_s                    cache_req_o;
  logic                          cache_req_v_o;
  logic                          cache_req_ready_i;
  cache_req_metadata_s           cache_req_metadata_o;
  logic                          cache_req_metadata_v_o;
  logic                          cache_req_complete_i;
  logic                          tag_mem_pkt_v_i;
  tag_mem_pkt_s                  tag_mem_pkt_i;
  logic                          tag_mem_pkt_ready_o;
  logic                          data_mem_pkt_v_i;
  data_mem_pkt_s                 data_mem_pkt_i;
  logic                          data_mem_pkt_ready_o;

  // reference model of the cache contents
  logic [tag_width_lp-1:0]   m_tag   [sets_lp][ways_lp];
  logic                      m_valid [sets_lp][ways_lp];
  logic [block_width_lp-1:0] m_block [sets_lp][ways_lp];
  logic [lru_width_lp-1:0]   m_lru   [sets_lp];

  integer                     seed = 85;
  int                         errors;
  int                         errors_at_start;
  int                         tests_run;
  logic [way_id_width_lp-1:0] pending_way;

  icache u_icache (.*);

  always #10 clk_i = ~clk_i;

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_instr(input string name, input logic [instr_width_lp-1:0] got,
                             input logic [instr_width_lp-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_req(input string name, input cache_req_s got, input cache_req_s exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got.addr, exp.addr);
      errors++;
    end
  endtask

  task automatic check_meta(input string name, input cache_req_metadata_s got,
                            input cache_req_metadata_s exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got.repl_way, exp.repl_way);
      errors++;
    end
  endtask

  function automatic logic [paddr_width_lp-1:0] make_addr(input logic [tag_width_lp-1:0] tag,
      input logic [index_width_lp-1:0] idx, input logic [block_offset_width_lp-1:0] off);
    return {tag, idx, off};
  endfunction

  // only the page offset matches the physical address
  function automatic logic [paddr_width_lp-1:0] vaddr_of(input logic [paddr_width_lp-1:0] a);
    return {~a[paddr_width_lp-1:page_offset_width_lp], a[page_offset_width_lp-1:0]};
  endfunction

  function automatic logic [block_width_lp-1:0] random_block();
    logic [block_width_lp-1:0] blk;
    for (int i = 0; i < block_width_lp / instr_width_lp; i++) begin
      blk[i*instr_width_lp +: instr_width_lp] = $random(seed);
    end
    return blk;
  endfunction

  function automatic logic model_find(input logic [paddr_width_lp-1:0] addr,
                                      output logic [way_id_width_lp-1:0] way);
    logic [index_width_lp-1:0] s;
    s = addr[block_offset_width_lp +: index_width_lp];
    way = '0;
    for (int w = ways_lp - 1; w >= 0; w--) begin
      if (m_valid[s][w] && m_tag[s][w] == addr[paddr_width_lp-1 -: tag_width_lp]) begin
        way = way_id_width_lp'(w);
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // lowest invalid way, otherwise follow the tree
  function automatic logic [way_id_width_lp-1:0] model_victim(input logic [index_width_lp-1:0] s);
    logic [way_id_width_lp-1:0] v;
    v = m_lru[s][0] ? {1'b1, m_lru[s][2]} : {1'b0, m_lru[s][1]};
    for (int w = ways_lp - 1; w >= 0; w--) begin
      if (!m_valid[s][w]) v = way_id_width_lp'(w);
    end
    return v;
  endfunction

  function automatic void model_touch(input logic [index_width_lp-1:0] s,
                                      input logic [way_id_width_lp-1:0] way);
    m_lru[s][0] = ~way[1];
    if (way[1]) m_lru[s][2] = ~way[0];
    else m_lru[s][1] = ~way[0];
  endfunction

  task automatic wait_ready(input int which, input string what);
    int   n = 0;
    logic rdy = 1'b0;
    while (!rdy && n <= timeout_cycles_lp) begin
      @(negedge clk_i);
      case (which)
        0:       rdy = vaddr_ready_o;
        1:       rdy = tag_mem_pkt_ready_o;
        default: rdy = data_mem_pkt_ready_o;
      endcase
      n++;
    end
    if (!rdy) begin
      $display("timeout waiting for %s", what);
      $display("Test failures found");
      $finish;
    end
  endtask

  task automatic send_tag(input tag_opcode_e op, input logic [index_width_lp-1:0] idx,
      input logic [way_id_width_lp-1:0] way, input coh_state_e st,
      input logic [tag_width_lp-1:0] tag);
    tag_mem_pkt_s pkt;
    pkt.opcode = op;
    pkt.index  = idx;
    pkt.way_id = way;
    pkt.state  = st;
    pkt.tag    = tag;
    wait_ready(1, "tag_mem_pkt_ready_o");
    @(posedge clk_i);
    tag_mem_pkt_v_i <= 1'b1;
    tag_mem_pkt_i   <= pkt;
    @(posedge clk_i);
    tag_mem_pkt_v_i <= 1'b0;
    case (op)
      e_tag_set_clear: begin
        for (int w = 0; w < ways_lp; w++) begin
          m_valid[idx][w] = 1'b0;
          m_tag[idx][w]   = '0;
        end
        m_lru[idx] = '0;
      end
      e_tag_invalidate: m_valid[idx][way] = 1'b0;
      default: begin
        m_valid[idx][way] = (st == e_coh_s);
        m_tag[idx][way]   = tag;
      end
    endcase
  endtask

  task automatic send_data(input logic [index_width_lp-1:0] idx,
      input logic [way_id_width_lp-1:0] way, input logic [block_width_lp-1:0] blk);
    data_mem_pkt_s pkt;
    pkt.index  = idx;
    pkt.way_id = way;
    pkt.data   = blk;
    wait_ready(2, "data_mem_pkt_ready_o");
    @(posedge clk_i);
    data_mem_pkt_v_i <= 1'b1;
    data_mem_pkt_i   <= pkt;
    @(posedge clk_i);
    data_mem_pkt_v_i <= 1'b0;
    m_block[idx][way] = blk;
  endtask

  // returns at the start of the TV cycle
  task automatic issue_fetch(input logic [paddr_width_lp-1:0] addr);
    wait_ready(0, "vaddr_ready_o");
    @(posedge clk_i);
    vaddr_i   <= vaddr_of(addr);
    vaddr_v_i <= 1'b1;
    @(negedge clk_i);
    check_flag("vaddr_ready_o", vaddr_ready_o, 1'b1);
    // the lookup owns the memory port in the acceptance cycle
    check_flag("tag_mem_pkt_ready_o", tag_mem_pkt_ready_o, 1'b0);
    check_flag("data_mem_pkt_ready_o", data_mem_pkt_ready_o, 1'b0);
    @(posedge clk_i);
    vaddr_v_i <= 1'b0;
    ptag_i    <= addr[paddr_width_lp-1:page_offset_width_lp];
    ptag_v_i  <= 1'b1;
    @(posedge clk_i);
    ptag_v_i  <= 1'b0;
  endtask

  task automatic expect_hit(input logic [paddr_width_lp-1:0] addr);
    logic [way_id_width_lp-1:0] way;
    logic [index_width_lp-1:0]  s;
    logic [instr_width_lp-1:0]  exp;
    s = addr[block_offset_width_lp +: index_width_lp];
    if (!model_find(addr, way)) begin
      $display("no line for address %h in the model, hit cannot be predicted", addr);
      errors++;
      return;
    end
    exp = m_block[s][way][int'(addr[5:2]) * instr_width_lp +: instr_width_lp];
    issue_fetch(addr);
    @(negedge clk_i);
    check_flag("data_v_o", data_v_o, 1'b1);
    check_flag("cache_req_v_o", cache_req_v_o, 1'b0);
    check_instr("data_o", data_o, exp);
    model_touch(s, way);
  endtask

  task automatic expect_miss(input logic [paddr_width_lp-1:0] addr,
                             output logic [way_id_width_lp-1:0] way);
    cache_req_s          exp_req;
    cache_req_metadata_s exp_meta;
    exp_req.addr      = addr;
    exp_meta.repl_way = model_victim(addr[block_offset_width_lp +: index_width_lp]);
    way               = exp_meta.repl_way;
    issue_fetch(addr);
    @(negedge clk_i);
    check_flag("data_v_o", data_v_o, 1'b0);
    check_flag("cache_req_v_o", cache_req_v_o, 1'b1);
    check_req("cache_req_o", cache_req_o, exp_req);
    check_flag("cache_req_metadata_v_o", cache_req_metadata_v_o, 1'b0);
    check_flag("miss_o", miss_o, 1'b0);
    @(negedge clk_i);
    check_flag("cache_req_metadata_v_o", cache_req_metadata_v_o, 1'b1);
    check_meta("cache_req_metadata_o", cache_req_metadata_o, exp_meta);
    check_flag("miss_o", miss_o, 1'b1);
    check_flag("vaddr_ready_o", vaddr_ready_o, 1'b0);
  endtask

  task automatic complete_fill();
    @(posedge clk_i);
    cache_req_complete_i <= 1'b1;
    @(negedge clk_i);
    check_flag("miss_o", miss_o, 1'b1);
    @(posedge clk_i);
    cache_req_complete_i <= 1'b0;
    @(negedge clk_i);
    check_flag("miss_o", miss_o, 1'b0);
  endtask

  task automatic fill_line(input logic [paddr_width_lp-1:0] addr,
                           input logic [way_id_width_lp-1:0] way);
    logic [index_width_lp-1:0] s;
    s = addr[block_offset_width_lp +: index_width_lp];
    send_tag(e_tag_set_tag, s, way, e_coh_s, addr[paddr_width_lp-1 -: tag_width_lp]);
    send_data(s, way, random_block());
    complete_fill();
  endtask

  task automatic miss_and_fill(input logic [paddr_width_lp-1:0] addr);
    logic [way_id_width_lp-1:0] way;
    expect_miss(addr, way);
    fill_line(addr, way);
    expect_hit(addr);
  endtask

  // one fetch per cycle with each ptag one cycle behind its vaddr
  task automatic fetch_stream(input logic [paddr_width_lp-1:0] base, input int n);
    logic [paddr_width_lp-1:0]  addrs [16];
    logic [instr_width_lp-1:0]  exp   [16];
    logic [way_id_width_lp-1:0] ways  [16];
    logic [index_width_lp-1:0]  s;
    s = base[block_offset_width_lp +: index_width_lp];
    for (int i = 0; i < n; i++) begin
      addrs[i] = base + paddr_width_lp'(4 * i);
      if (!model_find(addrs[i], ways[i])) begin
        $display("no line for address %h in the model, hit cannot be predicted", addrs[i]);
        errors++;
      end
      exp[i] = m_block[s][ways[i]][int'(addrs[i][5:2]) * instr_width_lp +: instr_width_lp];
    end
    wait_ready(0, "vaddr_ready_o");
    for (int c = 0; c < n + 2; c++) begin
      @(posedge clk_i);
      vaddr_v_i <= (c < n);
      if (c < n) vaddr_i <= vaddr_of(addrs[c]);
      ptag_v_i  <= (c >= 1 && c <= n);
      if (c >= 1 && c <= n) ptag_i <= addrs[c-1][paddr_width_lp-1:page_offset_width_lp];
      @(negedge clk_i);
      if (c < n) check_flag("vaddr_ready_o", vaddr_ready_o, 1'b1);
      if (c >= 2) begin
        check_flag("data_v_o", data_v_o, 1'b1);
        check_instr("data_o", data_o, exp[c-2]);
        model_touch(s, ways[c-2]);
      end else begin
        check_flag("data_v_o", data_v_o, 1'b0);
      end
    end
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_at_start) $display("test %s: pass", name);
    else $display("test %s: FAIL, %0d errors", name, errors - errors_at_start);
  endtask

  initial begin
    clk_i                = 1'b0;
    reset_i              = 1'b1;
    vaddr_i              = '0;
    vaddr_v_i            = 1'b0;
    ptag_i               = '0;
    ptag_v_i             = 1'b0;
    cache_req_ready_i    = 1'b1;
    cache_req_complete_i = 1'b0;
    tag_mem_pkt_v_i      = 1'b0;
    tag_mem_pkt_i        = '0;
    data_mem_pkt_v_i     = 1'b0;
    data_mem_pkt_i       = '0;
    errors               = 0;
    tests_run            = 0;
    for (int s = 0; s < sets_lp; s++) begin
      m_lru[s] = '0;
      for (int w = 0; w < ways_lp; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
      end
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    start_test();
    @(negedge clk_i);
    check_flag("data_v_o", data_v_o, 1'b0);
    check_flag("cache_req_v_o", cache_req_v_o, 1'b0);
    check_flag("cache_req_metadata_v_o", cache_req_metadata_v_o, 1'b0);
    check_flag("miss_o", miss_o, 1'b0);
    for (int s = 0; s < sets_lp; s++) begin
      send_tag(e_tag_set_clear, index_width_lp'(s), '0, e_coh_i, '0);
    end
    finish_test("reset_and_clear");

    start_test();
    expect_miss(make_addr(20'h00012, 6'd13, 6'h04), pending_way);
    check_meta("cache_req_metadata_o", cache_req_metadata_o, '{repl_way: 2'd0});
    repeat (6) begin
      @(negedge clk_i);
      check_flag("miss_o", miss_o, 1'b1);
      check_flag("vaddr_ready_o", vaddr_ready_o, 1'b0);
      check_flag("cache_req_v_o", cache_req_v_o, 1'b0);
      check_flag("cache_req_metadata_v_o", cache_req_metadata_v_o, 1'b0);
    end
    finish_test("cold_miss");

    start_test();
    fill_line(make_addr(20'h00012, 6'd13, 6'h04), pending_way);
    expect_hit(make_addr(20'h00012, 6'd13, 6'h04));
    finish_test("fill_and_hit");

    start_test();
    fetch_stream(make_addr(20'h00012, 6'd13, 6'h00), 16);
    finish_test("back_to_back_hits");

    start_test();
    for (int k = 0; k < ways_lp; k++) begin
      miss_and_fill(make_addr(20'h00100 + tag_width_lp'(k), 6'd10, 6'h08));
    end
    expect_hit(make_addr(20'h00102, 6'd10, 6'h08));
    expect_hit(make_addr(20'h00100, 6'd10, 6'h0c));
    expect_hit(make_addr(20'h00103, 6'd10, 6'h3c));
    miss_and_fill(make_addr(20'h001a5, 6'd10, 6'h10));
    finish_test("replacement");

    start_test();
    send_tag(e_tag_invalidate, 6'd10, 2'd2, e_coh_i, '0);
    miss_and_fill(make_addr(20'h00102, 6'd10, 6'h08));
    finish_test("invalidate");

    $display("tests run %0d, checks failed %0d", tests_run, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- icache.f
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_lru.sv
icache_miss_fsm.sv
icache_lookup.sv
icache.sv
icache_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= icache_tb
RTL_TOP    ?= icache
FILELIST   ?= icache.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
